// ==== common/decode_defines.svh ====
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// Widths
`define DEC_XLEN            32
`define DEC_REG_W           5

`define DEC_PC_RESET        32'h8000_0000   // First fetch address

// ------------------------------
// RV32I major opcodes
`define DEC_OP_LUI          7'b0110111
`define DEC_OP_AUIPC        7'b0010111
`define DEC_OP_JAL          7'b1101111
`define DEC_OP_JALR         7'b1100111
`define DEC_OP_BRANCH       7'b1100011
`define DEC_OP_LOAD         7'b0000011
`define DEC_OP_STORE        7'b0100011
`define DEC_OP_OP_IMM       7'b0010011
`define DEC_OP_OP           7'b0110011

// Trap causes, carried in rd
`define DEC_TRAP_IACCESS    5'd1
`define DEC_TRAP_IOPCODE    5'd2

`endif

// ==== common/decode_pkg.sv ====
`default_nettype none

`include "decode_defines.svh"

package decode_pkg;

    // ------------------------------
    // Instruction word views
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // S, B and J immediates are scattered, read them from raw
    typedef union packed {
        logic [31:0] raw;
        r_fmt_t      r;
        i_fmt_t      i;
    } instr_word_u;

    // ------------------------------
    // Functional unit, one-hot
    typedef enum logic [3:0] {
        FU_NONE = 4'b0000,
        FU_ALU  = 4'b0001,
        FU_CFU  = 4'b0010,
        FU_LSU  = 4'b0100
    } fu_t;

    typedef logic [4:0] uop_t;

    localparam uop_t ALU_ADD  = 5'd0;
    localparam uop_t ALU_SUB  = 5'd1;
    localparam uop_t ALU_AND  = 5'd2;
    localparam uop_t ALU_OR   = 5'd3;
    localparam uop_t ALU_XOR  = 5'd4;
    localparam uop_t ALU_SLT  = 5'd5;
    localparam uop_t ALU_SLTU = 5'd6;
    localparam uop_t ALU_SLL  = 5'd7;
    localparam uop_t ALU_SRL  = 5'd8;
    localparam uop_t ALU_SRA  = 5'd9;

    localparam uop_t CFU_BEQ  = 5'd0;
    localparam uop_t CFU_BNE  = 5'd1;
    localparam uop_t CFU_BLT  = 5'd2;
    localparam uop_t CFU_BGE  = 5'd3;
    localparam uop_t CFU_BLTU = 5'd4;
    localparam uop_t CFU_BGEU = 5'd5;
    localparam uop_t CFU_JALI = 5'd6;
    localparam uop_t CFU_JALR = 5'd7;

    // LSU uop is a bit field, width lives in bits 2:1
    localparam int         LSU_LOAD   = 0;
    localparam int         LSU_STORE  = 3;
    localparam int         LSU_SIGNED = 4;
    localparam logic [1:0] LSU_BYTE   = 2'd1;
    localparam logic [1:0] LSU_HALF   = 2'd2;
    localparam logic [1:0] LSU_WORD   = 2'd3;

    // ------------------------------
    typedef struct packed {
        logic a_rs1;
        logic a_pcim;
        logic b_rs2;
        logic b_imm;
        logic c_rs2;
        logic c_pcim;
    } opr_src_t;

    typedef struct packed {
        fu_t                   fu;
        uop_t                  uop;
        logic [`DEC_REG_W-1:0] rd;
        opr_src_t              opr_src;
        logic                  trap;
    } dec_ctrl_t;

    typedef struct packed {
        logic [`DEC_REG_W-1:0] rd;
        logic [`DEC_XLEN-1:0]  opr_a;
        logic [`DEC_XLEN-1:0]  opr_b;
        logic [`DEC_XLEN-1:0]  opr_c;
        uop_t                  uop;
        fu_t                   fu;
        logic                  trap;
    } stage_out_t;

endpackage

`default_nettype wire

// ==== decoder/instr_classify.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_defines.svh"

module instr_classify
    import decode_pkg::*;
(
    input  instr_word_u           instr,
    input  logic                  valid,
    input  logic                  fetch_error,
    output logic [`DEC_REG_W-1:0] rs1_addr,
    output logic [`DEC_REG_W-1:0] rs2_addr,
    output dec_ctrl_t             ctrl
);

    fu_t                   fu;
    uop_t                  uop;
    opr_src_t              src;
    logic                  no_rd;      // Stores and branches write nothing
    logic                  illegal;
    logic                  trap;
    logic [`DEC_REG_W-1:0] rd;
    logic [2:0]            f3;
    logic [6:0]            f7;

    function automatic uop_t alu_uop(input logic [2:0] funct3, input logic alt);
        uop_t op;
        case (funct3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    function automatic logic [1:0] lsu_width(input logic [1:0] size);
        logic [1:0] w;
        case (size)
            2'b00:   w = LSU_BYTE;
            2'b01:   w = LSU_HALF;
            default: w = LSU_WORD;
        endcase
        return w;
    endfunction

    assign f3       = instr.r.funct3;
    assign f7       = instr.r.funct7;
    assign rs1_addr = instr.r.rs1;
    assign rs2_addr = instr.r.rs2;

    // ------------------------------
    always_comb begin
        fu      = FU_NONE;
        uop     = '0;
        src     = '0;
        no_rd   = 1'b0;
        illegal = 1'b0;
        case (instr.r.opcode)
            `DEC_OP_LUI: begin
                fu        = FU_ALU;
                uop       = ALU_OR;                     // Zero OR imm
                src.b_imm = 1'b1;
            end
            `DEC_OP_AUIPC: begin
                fu         = FU_ALU;
                uop        = ALU_ADD;                   // PC+imm plus zero
                src.a_pcim = 1'b1;
            end
            `DEC_OP_OP: begin
                fu        = FU_ALU;
                uop       = alu_uop(f3, f7[5]);
                src.a_rs1 = 1'b1;
                src.b_rs2 = 1'b1;
                illegal   = !(f7 == 7'b0000000 ||
                              (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101)));
            end
            `DEC_OP_OP_IMM: begin
                fu        = FU_ALU;
                uop       = alu_uop(f3, f3 == 3'b101 && f7[5]);   // No SUBI
                src.a_rs1 = 1'b1;
                src.b_imm = 1'b1;
                illegal   = (f3 == 3'b001 && f7 != 7'b0000000) ||
                            (f3 == 3'b101 && f7 != 7'b0000000 && f7 != 7'b0100000);
            end
            `DEC_OP_LOAD: begin
                fu              = FU_LSU;
                uop[LSU_LOAD]   = 1'b1;
                uop[LSU_SIGNED] = !f3[2] && f3[1:0] != 2'b10;   // LB and LH
                uop[2:1]        = lsu_width(f3[1:0]);
                src.a_rs1       = 1'b1;
                src.b_imm       = 1'b1;
                illegal         = f3 == 3'b011 || f3[2:1] == 2'b11;
            end
            `DEC_OP_STORE: begin
                fu             = FU_LSU;
                uop[LSU_STORE] = 1'b1;
                uop[2:1]       = lsu_width(f3[1:0]);
                src.a_rs1      = 1'b1;
                src.b_imm      = 1'b1;
                src.c_rs2      = 1'b1;                  // Store data
                no_rd          = 1'b1;
                illegal        = f3[2] || f3[1:0] == 2'b11;
            end
            `DEC_OP_BRANCH: begin
                fu         = FU_CFU;
                src.a_rs1  = 1'b1;
                src.b_rs2  = 1'b1;
                src.c_pcim = 1'b1;                      // Branch target
                no_rd      = 1'b1;
                illegal    = f3[2:1] == 2'b01;
                case (f3)
                    3'b000:  uop = CFU_BEQ;
                    3'b001:  uop = CFU_BNE;
                    3'b100:  uop = CFU_BLT;
                    3'b101:  uop = CFU_BGE;
                    3'b110:  uop = CFU_BLTU;
                    default: uop = CFU_BGEU;
                endcase
            end
            `DEC_OP_JAL: begin
                fu         = FU_CFU;
                uop        = CFU_JALI;
                src.c_pcim = 1'b1;
            end
            `DEC_OP_JALR: begin
                fu        = FU_CFU;
                uop       = CFU_JALR;
                src.a_rs1 = 1'b1;
                src.b_imm = 1'b1;
                illegal   = f3 != 3'b000;
            end
            default: illegal = 1'b1;
        endcase
        if (illegal) begin
            fu    = FU_NONE;
            uop   = '0;
            src   = '0;
            no_rd = 1'b0;
        end
    end

    // ------------------------------
    // Trap cause rides in rd, opcode errors first
    assign trap = valid && (illegal || fetch_error);
    assign rd   = trap  ? (illegal ? `DEC_TRAP_IOPCODE : `DEC_TRAP_IACCESS) :
                  no_rd ? '0 : instr.r.rd;

    assign ctrl = '{fu: fu, uop: uop, rd: rd, opr_src: src, trap: trap};

endmodule

`default_nettype wire

// ==== decoder/imm_extract.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_defines.svh"

module imm_extract
    import decode_pkg::*;
(
    input  instr_word_u          instr,
    output logic [`DEC_XLEN-1:0] imm,
    output logic [`DEC_XLEN-1:0] pc_imm
);

    logic [31:0]          w;
    logic [`DEC_XLEN-1:0] imm_i;
    logic [`DEC_XLEN-1:0] imm_s;
    logic [`DEC_XLEN-1:0] imm_b;
    logic [`DEC_XLEN-1:0] imm_u;
    logic [`DEC_XLEN-1:0] imm_j;
    logic [`DEC_XLEN-1:0] imm_sh;
    logic                 is_shift;

    assign w = instr.raw;

    // ------------------------------
    assign imm_i  = {{(`DEC_XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
    assign imm_s  = {{(`DEC_XLEN-12){w[31]}}, w[31:25], w[11:7]};
    assign imm_b  = {{(`DEC_XLEN-13){w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    assign imm_u  = {w[31:12], 12'b0};
    assign imm_j  = {{(`DEC_XLEN-21){w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    assign imm_sh = {{(`DEC_XLEN-5){1'b0}}, instr.r.rs2};   // Shift amount only

    assign is_shift = instr.i.funct3[1:0] == 2'b01;         // SLLI, SRLI, SRAI

    // ------------------------------
    always_comb begin
        imm    = '0;
        pc_imm = '0;
        case (instr.i.opcode)
            `DEC_OP_BRANCH:             pc_imm = imm_b;
            `DEC_OP_JAL:                pc_imm = imm_j;
            `DEC_OP_AUIPC:              pc_imm = imm_u;
            `DEC_OP_LUI:                imm    = imm_u;
            `DEC_OP_JALR, `DEC_OP_LOAD: imm    = imm_i;
            `DEC_OP_STORE:              imm    = imm_s;
            `DEC_OP_OP_IMM:             imm    = is_shift ? imm_sh : imm_i;
            default:                    imm    = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/program_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_defines.svh"

module program_counter (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    input  logic                 advance,     // Instruction accepted
    input  logic                 redirect,    // Control flow change taken
    input  logic [`DEC_XLEN-1:0] target,
    output logic [`DEC_XLEN-1:0] pc
);

    localparam logic [`DEC_XLEN-1:0] PC_STEP = 4;   // RV32I only, no compressed

    logic [`DEC_XLEN-1:0] pc_q;

    // ------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc_q <= `DEC_PC_RESET;
        end else if (redirect) begin
            pc_q <= target;                  // Wins over advance
        end else if (advance) begin
            pc_q <= pc_q + PC_STEP;
        end
    end

    assign pc = pc_q;

endmodule

`default_nettype wire

// ==== logic/operand_select.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_defines.svh"

module operand_select
    import decode_pkg::*;
(
    input  opr_src_t             opr_src,
    input  logic [`DEC_XLEN-1:0] pc,
    input  logic [`DEC_XLEN-1:0] pc_imm,
    input  logic [`DEC_XLEN-1:0] imm,
    input  logic [`DEC_XLEN-1:0] rs1_rdata,
    input  logic [`DEC_XLEN-1:0] rs2_rdata,
    output logic [`DEC_XLEN-1:0] opr_a,
    output logic [`DEC_XLEN-1:0] opr_b,
    output logic [`DEC_XLEN-1:0] opr_c
);

    logic [`DEC_XLEN-1:0] pc_plus_imm;

    assign pc_plus_imm = pc + pc_imm;        // Branch, JAL and AUIPC targets

    // ------------------------------
    // AND-OR mux, no source gives zero
    assign opr_a = ({`DEC_XLEN{opr_src.a_rs1}}  & rs1_rdata) |
                   ({`DEC_XLEN{opr_src.a_pcim}} & pc_plus_imm);

    assign opr_b = ({`DEC_XLEN{opr_src.b_rs2}}  & rs2_rdata) |
                   ({`DEC_XLEN{opr_src.b_imm}}  & imm);

    assign opr_c = ({`DEC_XLEN{opr_src.c_rs2}}  & rs2_rdata) |     // Store data
                   ({`DEC_XLEN{opr_src.c_pcim}} & pc_plus_imm);    // Jump target

endmodule

`default_nettype wire

// ==== logic/decode_stage_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage_reg
    import decode_pkg::*;
(
    input  logic       g_clk,
    input  logic       g_resetn,
    input  logic       in_valid,
    input  stage_out_t in_data,
    input  logic       flush,
    input  logic       bubble,
    output logic       in_busy,
    output logic       out_valid,
    input  logic       out_busy,
    output stage_out_t out_data
);

    logic       valid_q;
    logic       stall;
    stage_out_t entry;
    stage_out_t data_q;

    assign stall   = valid_q && out_busy;   // Next stage holding our entry
    assign in_busy = stall || bubble;       // Bubble takes the slot

    // ------------------------------
    // Bubble keeps operands but kills control
    always_comb begin
        entry = in_data;
        if (bubble) begin
            entry.rd   = '0;
            entry.uop  = '0;
            entry.fu   = FU_NONE;
            entry.trap = 1'b0;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn || flush) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= in_valid || bubble;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!stall && (in_valid || bubble)) begin
            data_q <= entry;
        end
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;

endmodule

`default_nettype wire

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_defines.svh"

module decode_stage
    import decode_pkg::*;
(
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic                  s1_valid,
    output logic                  s1_busy,
    input  logic [31:0]           s1_data,
    input  logic                  s1_error,       // Fetch error on this word
    input  logic                  s1_flush,
    input  logic                  s1_bubble,
    output logic [`DEC_REG_W-1:0] s1_rs1_addr,
    output logic [`DEC_REG_W-1:0] s1_rs2_addr,
    input  logic [`DEC_XLEN-1:0]  s1_rs1_rdata,
    input  logic [`DEC_XLEN-1:0]  s1_rs2_rdata,
    input  logic                  cf_req,
    input  logic [`DEC_XLEN-1:0]  cf_target,
    input  logic                  cf_ack,
    output logic                  s2_valid,
    input  logic                  s2_busy,
    output stage_out_t            s2_out
);

    instr_word_u          instr;
    dec_ctrl_t            ctrl;
    logic [`DEC_XLEN-1:0] imm;
    logic [`DEC_XLEN-1:0] pc_imm;
    logic [`DEC_XLEN-1:0] pc;
    logic [`DEC_XLEN-1:0] opr_a;
    logic [`DEC_XLEN-1:0] opr_b;
    logic [`DEC_XLEN-1:0] opr_c;
    stage_out_t           stage_in;

    assign instr = s1_data;

    // ------------------------------
    instr_classify u_classify (
        .instr      (instr),
        .valid      (s1_valid),
        .fetch_error(s1_error),
        .rs1_addr   (s1_rs1_addr),
        .rs2_addr   (s1_rs2_addr),
        .ctrl       (ctrl)
    );

    imm_extract u_imm (
        .instr (instr),
        .imm   (imm),
        .pc_imm(pc_imm)
    );

    program_counter u_pc (
        .g_clk   (g_clk),
        .g_resetn(g_resetn),
        .advance (s1_valid && !s1_busy),   // Step on each transfer
        .redirect(cf_req && cf_ack),
        .target  (cf_target),
        .pc      (pc)
    );

    operand_select u_opr (
        .opr_src  (ctrl.opr_src),
        .pc       (pc),
        .pc_imm   (pc_imm),
        .imm      (imm),
        .rs1_rdata(s1_rs1_rdata),
        .rs2_rdata(s1_rs2_rdata),
        .opr_a    (opr_a),
        .opr_b    (opr_b),
        .opr_c    (opr_c)
    );

    assign stage_in = '{rd: ctrl.rd, opr_a: opr_a, opr_b: opr_b, opr_c: opr_c,
                        uop: ctrl.uop, fu: ctrl.fu, trap: ctrl.trap};

    decode_stage_reg u_reg (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .in_valid (s1_valid),
        .in_data  (stage_in),
        .flush    (s1_flush),
        .bubble   (s1_bubble),
        .in_busy  (s1_busy),
        .out_valid(s2_valid),
        .out_busy (s2_busy),
        .out_data (s2_out)
    );

endmodule

`default_nettype wire

// ==== tests/tb_decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_defines.svh"

module tb_decode_stage
    import decode_pkg::*;
();

    localparam int TIMEOUT = 50;    // Cycles per wait

    logic                  g_clk;
    logic                  g_resetn;
    logic                  s1_valid;
    logic                  s1_busy;
    logic [31:0]           s1_data;
    logic                  s1_error;
    logic                  s1_flush;
    logic                  s1_bubble;
    logic [`DEC_REG_W-1:0] s1_rs1_addr;
    logic [`DEC_REG_W-1:0] s1_rs2_addr;
    logic [`DEC_XLEN-1:0]  s1_rs1_rdata;
    logic [`DEC_XLEN-1:0]  s1_rs2_rdata;
    logic                  cf_req;
    logic [`DEC_XLEN-1:0]  cf_target;
    logic                  cf_ack;
    logic                  s2_valid;
    logic                  s2_busy;
    stage_out_t            s2_out;

    logic [31:0] rng_state;
    logic [31:0] exp_pc;         // PC tracked from transfers and redirects
    int          check_count;
    int          fail_count;

    decode_stage dut_i (.*);

    initial begin
        g_clk = 1'b0;
        forever #2 g_clk = ~g_clk;
    end

    function automatic logic [31:0] regfile_value(input logic [4:0] a);
        return {27'b0, a} * 32'h0101_0101;
    endfunction

    // Register file model answers in the same cycle
    assign s1_rs1_rdata = regfile_value(s1_rs1_addr);
    assign s1_rs2_rdata = regfile_value(s1_rs2_addr);

    // ------------------------------
    function automatic logic [31:0] rand32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Random word of the given opcode, funct fields forced legal
    function automatic logic [31:0] random_instr(input logic [6:0] op);
        logic [31:0] w;
        w = rand32();
        w[6:0] = op;
        case (op)
            `DEC_OP_OP: begin
                if (w[14:12] == 3'b000 || w[14:12] == 3'b101) w[31:25] = {1'b0, w[30], 5'b0};
                else w[31:25] = 7'b0;
            end
            `DEC_OP_OP_IMM: begin
                if (w[14:12] == 3'b001) w[31:25] = 7'b0;
                else if (w[14:12] == 3'b101) w[31:25] = {1'b0, w[30], 5'b0};
            end
            `DEC_OP_LOAD: begin
                if (w[13:12] == 2'b11 || w[14:13] == 2'b11) w[14:12] = 3'b010;
            end
            `DEC_OP_STORE: begin
                w[14] = 1'b0;
                if (w[13:12] == 2'b11) w[13:12] = 2'b00;
            end
            `DEC_OP_BRANCH: begin
                if (w[14:13] == 2'b01) w[14] = 1'b1;   // No funct3 010 or 011
            end
            `DEC_OP_JALR: w[14:12] = 3'b000;
            default: ;
        endcase
        return w;
    endfunction

    // ------------------------------
    // Reference model
    function automatic uop_t alu_code(input logic [2:0] f3, input logic alt);
        uop_t code;
        case ({alt, f3})
            4'b0_000: code = ALU_ADD;
            4'b1_000: code = ALU_SUB;
            4'b0_001: code = ALU_SLL;
            4'b0_010: code = ALU_SLT;
            4'b0_011: code = ALU_SLTU;
            4'b0_100: code = ALU_XOR;
            4'b0_101: code = ALU_SRL;
            4'b1_101: code = ALU_SRA;
            4'b0_110: code = ALU_OR;
            4'b0_111: code = ALU_AND;
            default:  code = '1;          // No such ALU op
        endcase
        return code;
    endfunction

    function automatic stage_out_t expected_out(input logic [31:0] w, input logic err,
                                                input logic [31:0] pc);
        stage_out_t  e;
        logic [2:0]  f3;
        logic [31:0] rs1_v;
        logic [31:0] rs2_v;
        logic [31:0] i_imm;
        logic [31:0] s_imm;
        logic [31:0] b_imm;
        logic [31:0] j_imm;
        logic [31:0] u_imm;
        f3    = w[14:12];
        rs1_v = regfile_value(w[19:15]);
        rs2_v = regfile_value(w[24:20]);
        i_imm = {{20{w[31]}}, w[31:20]};
        s_imm = {{20{w[31]}}, w[31:25], w[11:7]};
        b_imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        j_imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        u_imm = {w[31:12], 12'h000};
        e     = '0;
        e.rd  = w[11:7];
        case (w[6:0])
            `DEC_OP_LUI: begin
                e.fu    = FU_ALU;
                e.uop   = ALU_OR;
                e.opr_b = u_imm;
            end
            `DEC_OP_AUIPC: begin
                e.fu    = FU_ALU;
                e.uop   = ALU_ADD;
                e.opr_a = pc + u_imm;
            end
            `DEC_OP_OP: begin
                e.fu    = FU_ALU;
                e.uop   = alu_code(f3, w[30]);
                e.opr_a = rs1_v;
                e.opr_b = rs2_v;
            end
            `DEC_OP_OP_IMM: begin
                e.fu    = FU_ALU;
                e.uop   = alu_code(f3, f3 == 3'b101 && w[30]);
                e.opr_a = rs1_v;
                e.opr_b = (f3[1:0] == 2'b01) ? {27'b0, w[24:20]} : i_imm;   // Shamt
            end
            `DEC_OP_LOAD: begin
                e.fu       = FU_LSU;
                e.uop[0]   = 1'b1;
                e.uop[2:1] = f3[1:0] + 2'd1;
                e.uop[4]   = f3 == 3'b000 || f3 == 3'b001;               // LB and LH
                e.opr_a    = rs1_v;
                e.opr_b    = i_imm;
            end
            `DEC_OP_STORE: begin
                e.fu       = FU_LSU;
                e.uop[3]   = 1'b1;
                e.uop[2:1] = f3[1:0] + 2'd1;
                e.rd       = '0;
                e.opr_a    = rs1_v;
                e.opr_b    = s_imm;
                e.opr_c    = rs2_v;
            end
            `DEC_OP_BRANCH: begin
                e.fu    = FU_CFU;
                e.rd    = '0;
                e.opr_a = rs1_v;
                e.opr_b = rs2_v;
                e.opr_c = pc + b_imm;
                case (f3)
                    3'b000:  e.uop = CFU_BEQ;
                    3'b001:  e.uop = CFU_BNE;
                    3'b100:  e.uop = CFU_BLT;
                    3'b101:  e.uop = CFU_BGE;
                    3'b110:  e.uop = CFU_BLTU;
                    default: e.uop = CFU_BGEU;
                endcase
            end
            `DEC_OP_JAL: begin
                e.fu    = FU_CFU;
                e.uop   = CFU_JALI;
                e.opr_c = pc + j_imm;
            end
            `DEC_OP_JALR: begin
                e.fu    = FU_CFU;
                e.uop   = CFU_JALR;
                e.opr_a = rs1_v;
                e.opr_b = i_imm;
            end
            default: begin
                e.rd   = `DEC_TRAP_IOPCODE;
                e.trap = 1'b1;
            end
        endcase
        if (err && !e.trap) begin
            e.rd   = `DEC_TRAP_IACCESS;
            e.trap = 1'b1;
        end
        return e;
    endfunction

    // ------------------------------
    task automatic check_out(input string name, input stage_out_t exp, input stage_out_t got);
        check_count++;
        assert (got == exp) else begin
            $display("[FAIL] %s expected %h actual %h", name, exp, got);
            fail_count++;
        end
    endtask

    task automatic check_word(input string name, input string what,
                              input logic [31:0] exp, input logic [31:0] got);
        check_count++;
        assert (got == exp) else begin
            $display("[FAIL] %s %s expected %h actual %h", name, what, exp, got);
            fail_count++;
        end
    endtask

    task automatic abort_run(input string what);
        $display("Timeout while waiting for %s", what);
        $display("=== FAIL ===");
        $finish;
    endtask

    task automatic wait_not_busy();
        int t;
        t = 0;
        @(negedge g_clk);
        while (s1_busy) begin
            if (t == TIMEOUT) abort_run("s1_busy to drop");
            t++;
            @(negedge g_clk);
        end
    endtask

    task automatic wait_s2_valid();
        int t;
        t = 0;
        @(negedge g_clk);
        while (!s2_valid) begin
            if (t == TIMEOUT) abort_run("s2_valid");
            t++;
            @(negedge g_clk);
        end
    endtask

    task automatic send_instr(input logic [31:0] w, input logic err, output stage_out_t got);
        @(posedge g_clk);
        s1_valid <= 1'b1;
        s1_data  <= w;
        s1_error <= err;
        wait_not_busy();
        @(posedge g_clk);                     // Transfer edge
        s1_valid <= 1'b0;
        s1_error <= 1'b0;
        wait_s2_valid();
        got = s2_out;
    endtask

    task automatic send_and_check(input string name, input logic [31:0] w, input logic err);
        stage_out_t exp;
        stage_out_t got;
        exp = expected_out(w, err, exp_pc);
        send_instr(w, err, got);
        exp_pc = exp_pc + 32'd4;
        check_out(name, exp, got);
    endtask

    task automatic end_test(input string name, input int first);
        if (fail_count == first) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: errors", name);
        end
    endtask

    // ------------------------------
    task automatic control_flow();
        logic [31:0] w;
        int          first;
        first = fail_count;
        @(negedge g_clk);
        check_word("control_flow", "s2_valid after reset", 32'd0, {31'b0, s2_valid});
        send_and_check("control_flow", {20'h0, 5'd3, `DEC_OP_AUIPC}, 1'b0);  // Reset PC
        repeat (30) begin
            case (rand32() % 32'd4)
                0:       w = random_instr(`DEC_OP_BRANCH);
                1:       w = random_instr(`DEC_OP_JAL);
                2:       w = random_instr(`DEC_OP_JALR);
                default: w = random_instr(`DEC_OP_AUIPC);
            endcase
            send_and_check("control_flow", w, 1'b0);
        end
        end_test("control_flow", first);
    endtask

    task automatic alu_forms();
        logic [31:0] w;
        int          first;
        first = fail_count;
        repeat (40) begin
            case (rand32() % 32'd3)
                0:       w = random_instr(`DEC_OP_OP);
                1:       w = random_instr(`DEC_OP_OP_IMM);
                default: w = random_instr(`DEC_OP_LUI);
            endcase
            send_and_check("alu_forms", w, 1'b0);
        end
        end_test("alu_forms", first);
    endtask

    task automatic lsu_forms();
        logic [31:0] r;
        int          first;
        first = fail_count;
        repeat (30) begin
            r = rand32();
            send_and_check("lsu_forms", random_instr(r[0] ? `DEC_OP_STORE : `DEC_OP_LOAD), 1'b0);
        end
        end_test("lsu_forms", first);
    endtask

    task automatic redirect_pc();
        logic [31:0] r;
        logic [31:0] target;
        int          first;
        first = fail_count;
        repeat (8) begin
            r      = rand32();
            target = rand32() & 32'hFFFF_FFFC;
            @(posedge g_clk);
            cf_req    <= 1'b1;
            cf_ack    <= r[1];                 // Request without ack is ignored
            cf_target <= target;
            @(posedge g_clk);
            cf_req <= 1'b0;
            cf_ack <= 1'b0;
            if (r[1]) exp_pc = target;
            send_and_check("redirect_pc", random_instr(r[0] ? `DEC_OP_JAL : `DEC_OP_AUIPC), 1'b0);
        end
        end_test("redirect_pc", first);
    endtask

    task automatic trap_causes();
        logic [31:0] w;
        int          first;
        first = fail_count;
        repeat (10) begin
            w = rand32();
            w[6:0] = {w[6:5], 5'b01011};       // No RV32I opcode here
            send_and_check("trap_causes", w, w[31]);   // Opcode cause outranks fetch error
        end
        repeat (10) begin
            case (rand32() % 32'd4)
                0:       w = random_instr(`DEC_OP_OP_IMM);
                1:       w = random_instr(`DEC_OP_LOAD);
                2:       w = random_instr(`DEC_OP_BRANCH);
                default: w = random_instr(`DEC_OP_JAL);
            endcase
            send_and_check("trap_causes", w, 1'b1);
        end
        end_test("trap_causes", first);
    endtask

    task automatic pipeline_flow();
        stage_out_t  held;
        stage_out_t  got;
        logic [31:0] w;
        int          first;
        first = fail_count;
        // Back-pressure on the first entry
        w    = random_instr(`DEC_OP_OP_IMM);
        held = expected_out(w, 1'b0, exp_pc);
        @(posedge g_clk);
        s1_valid <= 1'b1;
        s1_data  <= w;
        wait_not_busy();
        @(posedge g_clk);
        exp_pc = exp_pc + 32'd4;
        s2_busy <= 1'b1;
        s1_data <= random_instr(`DEC_OP_JAL);   // Offered while stalled
        repeat (4) begin
            @(negedge g_clk);
            check_word("pipeline_flow", "stall s2_valid", 32'd1, {31'b0, s2_valid});
            check_word("pipeline_flow", "stall s1_busy", 32'd1, {31'b0, s1_busy});
            check_out("pipeline_flow", held, s2_out);
        end
        @(posedge g_clk);
        s2_busy  <= 1'b0;
        s1_valid <= 1'b0;
        send_and_check("pipeline_flow", random_instr(`DEC_OP_JAL), 1'b0);

        // Flush with the input still valid
        @(posedge g_clk);
        s1_valid <= 1'b1;
        s1_data  <= random_instr(`DEC_OP_OP);
        wait_not_busy();
        @(posedge g_clk);
        exp_pc = exp_pc + 32'd4;
        s1_flush <= 1'b1;
        @(negedge g_clk);
        check_word("pipeline_flow", "s2_valid before flush", 32'd1, {31'b0, s2_valid});
        @(posedge g_clk);
        exp_pc = exp_pc + 32'd4;                 // Flushed word still steps the PC
        s1_flush <= 1'b0;
        s1_valid <= 1'b0;
        @(negedge g_clk);
        check_word("pipeline_flow", "s2_valid after flush", 32'd0, {31'b0, s2_valid});

        // Bubble while fetch offers a word
        @(posedge g_clk);
        s1_valid  <= 1'b1;
        s1_data   <= random_instr(`DEC_OP_JAL);
        s1_bubble <= 1'b1;
        @(negedge g_clk);
        check_word("pipeline_flow", "bubble s1_busy", 32'd1, {31'b0, s1_busy});
        @(posedge g_clk);
        s1_bubble <= 1'b0;
        s1_valid  <= 1'b0;
        @(negedge g_clk);
        got = s2_out;
        check_word("pipeline_flow", "bubble s2_valid", 32'd1, {31'b0, s2_valid});
        check_word("pipeline_flow", "bubble control", 32'd0,
                   {17'b0, got.rd, got.uop, got.fu, got.trap});
        send_and_check("pipeline_flow", random_instr(`DEC_OP_JAL), 1'b0);  // PC unchanged
        end_test("pipeline_flow", first);
    endtask

    // ------------------------------
    initial begin
        g_resetn    = 1'b0;
        s1_valid    = 1'b0;
        s1_data     = 32'h0;
        s1_error    = 1'b0;
        s1_flush    = 1'b0;
        s1_bubble   = 1'b0;
        cf_req      = 1'b0;
        cf_target   = 32'h0;
        cf_ack      = 1'b0;
        s2_busy     = 1'b0;
        rng_state   = 32'd76;
        exp_pc      = `DEC_PC_RESET;
        check_count = 0;
        fail_count  = 0;
        repeat (16) @(posedge g_clk);
        g_resetn <= 1'b1;

        control_flow();
        alu_forms();
        lsu_forms();
        redirect_pc();
        trap_causes();
        pipeline_flow();

        $display("checks %0d, failures %0d", check_count, fail_count);
        if (fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+common
common/decode_pkg.sv
decoder/instr_classify.sv
decoder/imm_extract.sv
logic/program_counter.sv
logic/operand_select.sv
logic/decode_stage_reg.sv
logic/decode_stage.sv
tests/tb_decode_stage.sv

// ==== Makefile ====
# Verilator build and run of the RV32I decode stage testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search the log for failures"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f verilog.f --top-module tb_decode_stage -Mdir obj_dir
	@./obj_dir/Vtb_decode_stage > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "=== FAIL ===" $(LOG); then \
	    echo "Simulation failed"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)
